/* vlog.f */
+incdir+source
source/hexDisplayPkg.sv
source/rasterScanner.sv
source/hexGlyphPipe.sv
source/hexDisplay.sv
sim/hexDisplayChecker.sv
sim/hexDisplay_assertions.sv
sim/hexDisplayTb.sv

/* run.sh */
#!/bin/sh
# Build and run the hex display testbench with Verilator.
# Exits 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module hexDisplayTb -f vlog.f -o simv
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
  exit 0
fi
echo "pass line not found"
exit 1

/* sim/hexDisplayTb.sv */
// --------------------------------------------------------------------------
// Testbench for the hex display. One table entry per frame, run in order.
// The next word is driven at mid frame and is expected in the next frame.
// --------------------------------------------------------------------------
`include "hexDisplay_consts.svh"
`default_nettype none
`timescale 1ns/1ps

module hexDisplayTb
  import hexDisplayPkg::*;
();

  localparam int clkPeriod   = 8;
  localparam int worstDelay  = 8; // cycles per pixel under random returns, with slack
  localparam int framePixels = (1 << `HD_X_BITS) * (1 << `HD_Y_BITS);
  localparam int numTests    = 6;
  localparam int watchdogNs  = (numTests + 1) * framePixels * worstDelay * clkPeriod + 10000;

  localparam logic [1:0] modeImmediate = 2'd0;
  localparam logic [1:0] modeRandom    = 2'd1;
  localparam logic [1:0] modeStall     = 2'd2; // no returns for stallCycles, then immediate

  typedef struct packed {
    logic [95:0]              name;
    logic [`HD_DATA_BITS-1:0] word;
    logic [1:0]               mode;
    logic [15:0]              stallCycles;
    logic                     midReset;
  } testVec_t;

  localparam logic [`HD_DATA_BITS-1:0] digitsWord = {2{64'h0123456789ABCDEF}};
  localparam logic [`HD_DATA_BITS-1:0] allFWord   = {32{4'hF}};

  localparam testVec_t tests [numTests] = '{
    '{"digits",     digitsWord, modeImmediate, 16'd0, 1'b0},
    '{"allF",       allFWord, modeImmediate, 16'd0, 1'b0},
    '{"randDigits", digitsWord, modeRandom, 16'd0, 1'b0},
    '{"stallAllF",  allFWord, modeStall, 16'd300, 1'b0},
    '{"midReset",   128'hFEDCBA98_76543210_0F1E2D3C_4B5A6978, modeImmediate, 16'd0, 1'b1},
    '{"randMixed",  128'h00112233_44556677_8899AABB_CCDDEEFF, modeRandom, 16'd0, 1'b0}
  };

  logic                     clk;
  logic                     rst;
  logic [`HD_DATA_BITS-1:0] data;
  logic [95:0]              curName;
  logic                     creditReturn = 1'b0;
  pixelOut_t                pixOut;
  int                       curEntry;
  int                       lastEntry = -1;
  int                       stallLeft = 0;
  int                       owed = 0; // pixels the panel model still holds
  logic                     giveBack;
  logic [31:0]              lcgState = 32'h82c8;
  int                       frameNum;
  int                       pixInFrame;
  int                       testsPassed;
  int                       testsFailed;
  int                       otherErrors;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  hexDisplay hexDisplay_i
  (
    .clk          (clk),
    .rst          (rst),
    .data         (data),
    .creditReturn (creditReturn),
    .pixOut       (pixOut)
  );

  hexDisplayChecker hexDisplayChecker_i
  (
    .clk          (clk),
    .rst          (rst),
    .pixOut       (pixOut),
    .creditReturn (creditReturn),
    .frameWord    (data),
    .frameName    (curName),
    .frameNum     (frameNum),
    .pixInFrame   (pixInFrame),
    .testsPassed  (testsPassed),
    .testsFailed  (testsFailed),
    .otherErrors  (otherErrors)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // panel model, frees one slot per cycle at most
  always @(posedge clk)
  begin
    lcgState <= lcgNext(lcgState);
    giveBack = (owed > 0);
    case (tests[curEntry].mode)
      modeRandom: giveBack = giveBack && (lcgState[17:16] == 2'b00);
      modeStall:  giveBack = giveBack && (stallLeft == 0);
      default:    giveBack = giveBack;
    endcase
    if (curEntry != lastEntry)
      stallLeft <= int'(tests[curEntry].stallCycles); // new entry, reload the stall
    else if (stallLeft > 0)
      stallLeft <= stallLeft - 1;
    lastEntry <= curEntry;
    if (rst)
    begin
      owed         <= 0; // panel buffer flushed with the design
      creditReturn <= 1'b0;
    end
    else
    begin
      owed         <= owed + (pixOut.valid ? 1 : 0) - (giveBack ? 1 : 0);
      creditReturn <= giveBack;
    end
  end

  task automatic pulseReset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic runFrame(input int i);
    @(posedge clk);
    curEntry <= i;
    wait (frameNum == i && pixInFrame >= framePixels / 2);
    if (tests[i].midReset)
    begin
      pulseReset();
      wait (pixInFrame >= framePixels / 2);
    end
    if (i + 1 < numTests)
    begin
      @(posedge clk);
      data    <= tests[i + 1].word;
      curName <= tests[i + 1].name;
    end
    wait (frameNum == i + 1);
  endtask

  initial
  begin
    rst      = 1'b1;
    data     = tests[0].word;
    curName  = tests[0].name;
    curEntry = 0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < numTests; i++)
      runFrame(i);
    @(posedge clk);
    $display("tests passed %0d, failed %0d, other errors %0d",
             testsPassed, testsFailed, otherErrors);
    if (testsFailed == 0 && otherErrors == 0 && testsPassed == numTests)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    #(watchdogNs);
    $display("timeout: frames did not complete within %0d ns", watchdogNs);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/hexDisplay_assertions.sv */
// --------------------------------------------------------------------------
// Protocol assertions bound into hexDisplay.
// Reads the scanner credit counter through the instance hierarchy.
// --------------------------------------------------------------------------
`include "hexDisplay_consts.svh"
`default_nettype none
`timescale 1ns/1ps

module hexDisplayAssertions
  import hexDisplayPkg::*;
(
  input logic                                clk,
  input logic                                rst,
  input pixelReq_t                           req,
  input pixelOut_t                           pixOut,
  input logic [$clog2(`HD_CREDITS + 1)-1:0] credits
);

  // fixed pipe latency
  assert property (@(posedge clk) disable iff (rst) req.valid |-> ##4 pixOut.valid)
    else $error("request did not reach the output 4 cycles later");

  assert property (@(posedge clk) disable iff (rst) pixOut.valid |-> $past(req.valid, 4))
    else $error("output pixel without a request 4 cycles before");

  assert property (@(posedge clk) disable iff (rst) credits <= `HD_CREDITS)
    else $error("credit count above the panel buffer depth");

  assert property (@(posedge clk) rst |=> !pixOut.valid)
    else $error("valid output during reset");

endmodule

bind hexDisplay hexDisplayAssertions hexDisplayAssertions_i
(
  .clk     (clk),
  .rst     (rst),
  .req     (req),
  .pixOut  (pixOut),
  .credits (rasterScanner_i.credits)
);

`default_nettype wire

/* sim/hexDisplayChecker.sv */
// --------------------------------------------------------------------------
// Watches the display output and checks every pixel against the cell layout.
// The frame word comes from the testbench and is latched at each frame start.
// A reset restarts the expected scan at (0,0).
// --------------------------------------------------------------------------
`include "hexDisplay_consts.svh"
`default_nettype none
`timescale 1ns/1ps

module hexDisplayChecker
  import hexDisplayPkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  pixelOut_t                pixOut,
  input  logic                     creditReturn,
  input  logic [`HD_DATA_BITS-1:0] frameWord,
  input  logic [95:0]              frameName,
  output int                       frameNum,
  output int                       pixInFrame,
  output int                       testsPassed,
  output int                       testsFailed,
  output int                       otherErrors
);

  localparam int width       = 1 << `HD_X_BITS;
  localparam int height      = 1 << `HD_Y_BITS;
  localparam int framePixels = width * height;
  localparam int rowDigits   = 1 << `HD_ROW_BITS;

  logic [`HD_DATA_BITS-1:0] word; // word shown in the current frame
  logic [95:0]              name;
  color_t                   expColor;
  logic                     expLast;
  logic                     prevRst;
  int                       frameErrors;
  int                       owed; // pixels the panel has not returned

  // glyph sits in columns 0..4 and rows 0..4 of each 8x8 cell
  // bit 4 of a glyph row is column 0
  function automatic color_t refColor(input logic [`HD_DATA_BITS-1:0] w, input int p);
    int         px;
    int         py;
    int         digitNum;
    logic [3:0] nib;
    logic [4:0] bits;
    px       = p % width;
    py       = p / width;
    digitNum = (py / 8) * rowDigits + px / 8;
    nib      = w[digitNum * 4 +: 4];
    bits     = glyphRow(nib, 3'(py % 8));
    if ((px % 8) < 5 && (py % 8) < 5 && bits[4 - (px % 8)])
      return colorWhite;
    return digitColor(nib);
  endfunction

  initial
  begin
    frameNum    = 0;
    pixInFrame  = 0;
    testsPassed = 0;
    testsFailed = 0;
    otherErrors = 0;
    frameErrors = 0;
    owed        = 0;
    prevRst     = 1'b1;
  end

  always @(posedge clk)
  begin
    if (prevRst && pixOut.valid === 1'b1)
    begin
      $display("error: pixel output valid while the design was in reset");
      otherErrors++;
    end
    prevRst = rst;
    if (rst)
    begin
      pixInFrame = 0; // scan restarts at (0,0)
      owed       = 0;
    end
    else
    begin
      if (pixOut.valid === 1'b1)
      begin
        if (pixInFrame == 0)
        begin
          word = frameWord;
          name = frameName;
        end
        expColor = refColor(word, pixInFrame);
        expLast  = (pixInFrame == framePixels - 1);
        if (pixOut.color !== expColor)
        begin
          $display("mismatch %0s color at (%0d,%0d): expected %h, actual %h", name,
                   pixInFrame % width, pixInFrame / width, expColor, pixOut.color);
          frameErrors++;
        end
        if (pixOut.last !== expLast)
        begin
          $display("mismatch %0s last at (%0d,%0d): expected %b, actual %b", name,
                   pixInFrame % width, pixInFrame / width, expLast, pixOut.last);
          frameErrors++;
        end
        pixInFrame++;
        if (pixInFrame == framePixels)
        begin
          if (frameErrors == 0)
          begin
            $display("%0s: ok, %0d pixels", name, framePixels);
            testsPassed++;
          end
          else
          begin
            $display("%0s: %0d wrong pixels", name, frameErrors);
            testsFailed++;
          end
          frameErrors = 0;
          pixInFrame  = 0;
          frameNum++;
        end
      end
      owed = owed + (pixOut.valid === 1'b1 ? 1 : 0) - (creditReturn ? 1 : 0);
      if (owed > `HD_CREDITS)
      begin
        $display("error: %0d pixels held by the panel, buffer holds %0d", owed, `HD_CREDITS);
        otherErrors++;
      end
    end
  end

endmodule

`default_nettype wire

/* source/hexDisplay.sv */
// --------------------------------------------------------------------------
// Hex dump display top. Pixels leave 4 cycles after issue, one per cycle
// while credits last. The panel must return one credit per pixel taken.
// --------------------------------------------------------------------------
`include "hexDisplay_consts.svh"
`default_nettype none
`timescale 1ns/1ps

module hexDisplay
  import hexDisplayPkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`HD_DATA_BITS-1:0] data,
  input  logic                     creditReturn,
  output pixelOut_t                pixOut
);

  pixelReq_t req; // scanner to glyph pipe

  rasterScanner rasterScanner_i
  (
    .clk          (clk),
    .rst          (rst),
    .creditReturn (creditReturn),
    .req          (req)
  );

  hexGlyphPipe hexGlyphPipe_i
  (
    .clk    (clk),
    .rst    (rst),
    .data   (data),
    .req    (req),
    .pixOut (pixOut)
  );

endmodule

`default_nettype wire

/* source/hexGlyphPipe.sv */
// --------------------------------------------------------------------------
// Four stage glyph pipeline, one pixel per cycle, no stall.
// Digit n sits in data[4n+3:4n], counted left to right then top to bottom.
// The data word is sampled once per frame, at the request flagged first.
// --------------------------------------------------------------------------
`include "hexDisplay_consts.svh"
`default_nettype none
`timescale 1ns/1ps

module hexGlyphPipe
  import hexDisplayPkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`HD_DATA_BITS-1:0] data,
  input  pixelReq_t                req,
  output pixelOut_t                pixOut
);

  logic [`HD_DATA_BITS-1:0] snap; // frame snapshot

  logic                    s1Valid, s1Last;
  logic [`HD_ROW_BITS-1:0] s1Col;
  logic [2:0]              s1CellX;
  logic [`HD_Y_BITS-1:0]   s1Y;

  logic       s2Valid, s2Last;
  logic [3:0] s2Digit;
  logic [2:0] s2CellX;
  logic [2:0] s2Row;

  logic       s3Valid, s3Last;
  color_t     s3Bg;
  logic       s3On;

  logic       s4Valid, s4Last;
  color_t     s4Color;

  logic [`HD_Y_BITS-3+`HD_ROW_BITS-1:0] digitIdx; // cell row, then column
  logic [4:0]                           glyphBits;

  assign digitIdx  = {s1Y[`HD_Y_BITS-1:3], s1Col};
  assign glyphBits = glyphRow(s2Digit, s2Row);

  // valid and last walk along with the payload
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      {s1Valid, s2Valid, s3Valid, s4Valid} <= '0;
      {s1Last, s2Last, s3Last, s4Last}     <= '0;
    end
    else
    begin
      {s1Valid, s1Last} <= {req.valid, req.last};
      {s2Valid, s2Last} <= {s1Valid, s1Last};
      {s3Valid, s3Last} <= {s2Valid, s2Last};
      {s4Valid, s4Last} <= {s3Valid, s3Last};
    end
  end

  always_ff @(posedge clk)
  begin
    // stage 1: cell column and column within the cell
    s1Col   <= req.x[`HD_X_BITS-1:3];
    s1CellX <= req.x[2:0];
    s1Y     <= req.y;
    if (req.valid && req.first)
      snap <= data; // held for the whole frame
    // stage 2: pick the nibble
    s2Digit <= snap[{digitIdx, 2'b00} +: 4];
    s2CellX <= s1CellX;
    s2Row   <= s1Y[2:0];
    // stage 3
    s3Bg <= digitColor(s2Digit);
    s3On <= (s2CellX < 3'd5) ? glyphBits[3'd4 - s2CellX] : 1'b0; // gap columns 5..7
    // stage 4
    s4Color <= s3On ? colorWhite : s3Bg;
  end

  assign pixOut = '{valid: s4Valid, color: s4Color, last: s4Last};

endmodule

`default_nettype wire

/* source/rasterScanner.sv */
// --------------------------------------------------------------------------
// Raster scan source with credit flow control toward the panel buffer.
// Credit returns beyond HD_CREDITS outstanding are not guarded against.
// --------------------------------------------------------------------------
`include "hexDisplay_consts.svh"
`default_nettype none
`timescale 1ns/1ps

module rasterScanner
  import hexDisplayPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      creditReturn,
  output pixelReq_t req
);

  localparam int creditBits = $clog2(`HD_CREDITS + 1);

  logic [creditBits-1:0] credits; // free slots in the panel buffer
  logic [`HD_X_BITS-1:0] x;
  logic [`HD_Y_BITS-1:0] y;
  logic                  issue;

  assign issue = (credits != '0);

  // one credit out per issue, one back per return
  always_ff @(posedge clk)
  begin
    if (rst)
      credits <= creditBits'(`HD_CREDITS);
    else
    begin
      case ({issue, creditReturn})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits; // none, or both in the same cycle
      endcase
    end
  end

  // position advances only when a request goes out
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      x <= '0;
      y <= '0;
    end
    else if (issue)
    begin
      x <= x + 1'b1; // wraps at the right edge
      if (&x)
        y <= y + 1'b1; // wraps to the next frame after the bottom row
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      req <= '0;
    else
    begin
      req.valid <= issue;
      if (issue)
      begin
        req.x     <= x;
        req.y     <= y;
        req.first <= (x == '0) && (y == '0);
        req.last  <= (&x) && (&y); // (127,15)
      end
    end
  end

endmodule

`default_nettype wire

/* source/hexDisplayPkg.sv */
// --------------------------------------------------------------------------
// Pixel types, RGB565 palette and the 5x5 hex font of the display.
// Font rows use bit 4 for the leftmost glyph column. Rows 5 to 7 are blank.
// --------------------------------------------------------------------------
`include "hexDisplay_consts.svh"
`default_nettype none

package hexDisplayPkg;

  typedef logic [`HD_COLOR_BITS-1:0] color_t;

  typedef struct packed {
    logic                  valid;
    logic [`HD_X_BITS-1:0] x;
    logic [`HD_Y_BITS-1:0] y;
    logic                  first; // pixel (0,0)
    logic                  last;  // final pixel of the frame
  } pixelReq_t;

  typedef struct packed {
    logic   valid;
    color_t color;
    logic   last;
  } pixelOut_t;

  localparam color_t colorBlack = 16'h0000;
  localparam color_t colorWhite = 16'hFFFF; // lit glyph pixels

  // background per digit value, dark colors first, then gray and light ones
  localparam color_t palette [16] = '{
    colorBlack, 16'h4000, 16'h2100, 16'h4200, // black, dk red, dk brown, dk yellow
    16'h0200, 16'h0208, 16'h0008, 16'h4008,   // dk green, dk cyan, dk blue, dk violet
    16'h630C, 16'h8000, 16'h8200, 16'h8400,   // gray, lt red, orange, lt yellow
    16'h0400, 16'h0410, 16'h0010, 16'h8010    // lt green, lt cyan, lt blue, lt violet
  };

  localparam logic [4:0] fontRom [16][5] = '{
    '{5'b01110, 5'b10011, 5'b10101, 5'b11001, 5'b01110}, // 0
    '{5'b00100, 5'b01100, 5'b00100, 5'b00100, 5'b01110}, // 1
    '{5'b11110, 5'b00001, 5'b01110, 5'b10000, 5'b11111}, // 2
    '{5'b11110, 5'b00001, 5'b00110, 5'b00001, 5'b11110}, // 3
    '{5'b10010, 5'b10010, 5'b11111, 5'b00010, 5'b00010}, // 4
    '{5'b11111, 5'b10000, 5'b11110, 5'b00001, 5'b11110}, // 5
    '{5'b01110, 5'b10000, 5'b11110, 5'b10001, 5'b01110}, // 6
    '{5'b11111, 5'b00010, 5'b00100, 5'b01000, 5'b01000}, // 7
    '{5'b01110, 5'b10001, 5'b01110, 5'b10001, 5'b01110}, // 8
    '{5'b01110, 5'b10001, 5'b01111, 5'b00001, 5'b01110}, // 9
    '{5'b01110, 5'b10001, 5'b11111, 5'b10001, 5'b10001}, // A
    '{5'b11110, 5'b10001, 5'b11110, 5'b10001, 5'b11110}, // B
    '{5'b01111, 5'b10000, 5'b10000, 5'b10000, 5'b01111}, // C
    '{5'b11110, 5'b10001, 5'b10001, 5'b10001, 5'b11110}, // D
    '{5'b11111, 5'b10000, 5'b11110, 5'b10000, 5'b11111}, // E
    '{5'b11111, 5'b10000, 5'b11110, 5'b10000, 5'b10000}  // F
  };

  function automatic color_t digitColor(input logic [3:0] digit);
    return palette[digit];
  endfunction

  // one glyph row, bit 4 is the leftmost column
  function automatic logic [4:0] glyphRow(input logic [3:0] digit, input logic [2:0] row);
    if (row > 3'd4)
      return 5'b00000; // spacing rows below the glyph
    return fontRom[digit][row];
  endfunction

endpackage

`default_nettype wire

/* source/hexDisplay_consts.svh */
// --------------------------------------------------------------------------
// Geometry and sizing for the hex dump display on a 128x16 RGB565 panel.
// Two rows of 16 digits in 8x8 cells. DATA_BITS must equal 4 digits bits
// times columns times rows. HD_CREDITS must match the panel input buffer.
// --------------------------------------------------------------------------
`ifndef HEXDISPLAY_CONSTS_SVH
`define HEXDISPLAY_CONSTS_SVH
`default_nettype none

`define HD_DATA_BITS 128 // 32 hex digits
`define HD_ROW_BITS 4 // log2 of 16 digits per row
`define HD_X_BITS 7 // 128 pixels across
`define HD_Y_BITS 4 // 16 pixels down, two cell rows

// RGB565
`define HD_COLOR_BITS 16

// panel buffer depth, also the credit count after reset
`define HD_CREDITS 8

`default_nettype wire
`endif
